//--- include/control_checks.svh
/* Compare tasks for the cabinet ports and the common fail routine.
   Included inside the testbench module. */
`ifndef CONTROL_CHECKS_SVH
`define CONTROL_CHECKS_SVH

task automatic abort_run(input string why);
	$display("%s", why);
	$display("** FAIL **");
	$fatal(1, "run aborted");
endtask

task automatic check_port(input string what, input game_pkg::port_t got,
	input game_pkg::port_t exp);
	if (got !== exp)
	begin
		$display("MISMATCH %s got %h expected %h", what, got, exp);
		abort_run("joystick port differs from the expected value");
	end
endtask

task automatic check_btn(input string what, input game_pkg::btn_t got,
	input game_pkg::btn_t exp);
	if (got !== exp)
	begin
		$display("MISMATCH %s got %h expected %h", what, got, exp);
		abort_run("button port differs from the expected value");
	end
endtask

task automatic check_sw(input string what, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
	begin
		$display("MISMATCH %s got %h expected %h", what, got, exp);
		abort_run("switch port differs from the expected value");
	end
endtask

`endif

//--- rtl/ctrl_pkg.sv
/* Pad word, analog stick and stick position types shared by the control pipeline.
   Imported by the merge, quantize and mapper stages. */
package ctrl_pkg;

	typedef logic [15:0] pad_t;
	typedef logic signed [7:0] axis_t;
	typedef logic [3:0] stick_pos_t;

	// Pad word bits, bit 15 unused
	localparam int PAD_RIGHT   = 0;
	localparam int PAD_LEFT    = 1;
	localparam int PAD_DOWN    = 2;
	localparam int PAD_UP      = 3;
	localparam int PAD_FIRE_A  = 4;
	localparam int PAD_FIRE_B  = 5;
	localparam int PAD_FIRE_C  = 6;
	localparam int PAD_FIRE_D  = 7;
	localparam int PAD_FIRE_E  = 8;
	localparam int PAD_FIRE_F  = 9;
	localparam int PAD_START1  = 10;
	localparam int PAD_START2  = 11;
	localparam int PAD_COIN    = 12;
	localparam int PAD_ADVANCE = 13;
	localparam int PAD_AUTOUP  = 14;

	// Stick position codes as the game ROMs expect them
	localparam stick_pos_t POS_MIN    = 4'd0;
	localparam stick_pos_t POS_CENTER = 4'd7;
	localparam stick_pos_t POS_MAX    = 4'd8;

	// Analog bands and the in-between codes they produce
	localparam int AXIS_NEAR = 32;
	localparam int AXIS_MID  = 64;
	localparam int AXIS_FAR  = 96;
	localparam stick_pos_t POS_NEG_MID  = 4'd4;
	localparam stick_pos_t POS_NEG_NEAR = 4'd6;
	localparam stick_pos_t POS_POS_MID  = 4'd9;
	localparam stick_pos_t POS_POS_NEAR = 4'd11;

	////////////////////////////////////////////////////////////
	// Pipeline stage payloads

	typedef struct packed {
		pad_t pad1;
		pad_t pad2;
		pad_t any_pad;
		axis_t x;
		axis_t y;
	} merged_s;

	typedef struct packed {
		merged_s merged;
		stick_pos_t stick_x;
		stick_pos_t stick_y;
	} quant_s;

endpackage

//--- rtl/game_pkg.sv
/* Game selection, config write indices and the cabinet port layout.
   Used by the config block, the port mapper and the top level. */
package game_pkg;

	// Values match the game number loaded with the ROM set
	typedef enum logic [7:0] {
		ROBOTRON = 8'd0,
		JOUST    = 8'd1,
		BUBBLES  = 8'd3,
		ALIENAR  = 8'd5,
		SINISTAR = 8'd6
	} game_e;

	typedef enum logic [1:0] {
		FIRE_4WAY = 2'd0,
		MOVE_FIRE = 2'd1,
		CABINET   = 2'd2
	} ctrl_mode_e;

	// Config write indices
	localparam logic [7:0] CFG_GAME   = 8'd1;
	localparam logic [7:0] CFG_OPTION = 8'd2;
	localparam logic [7:0] CFG_DIP    = 8'd254;

	typedef logic [7:0] port_t;
	typedef logic [2:0] btn_t;

	// Board input ports, ja/jb/btn are active low
	typedef struct packed {
		port_t ja;
		port_t jb;
		btn_t btn;
		logic [7:0] sw;
	} cabinet_s;

	localparam cabinet_s CAB_IDLE = '{ja: 8'hff, jb: 8'hff, btn: 3'b111, sw: 8'h00};

endpackage

//--- rtl/game_config.sv
/* Game select, DIP byte and control-mode option, loaded through indexed config writes.
   Config is only changed while the input pipeline is empty. */
`timescale 1ns/1ns

module game_config
	import game_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       cfg_wr,
	input  logic [7:0] cfg_index,
	input  logic [2:0] cfg_addr,
	input  logic [7:0] cfg_data,
	output game_e      game,
	output ctrl_mode_e mode,
	output logic [7:0] dip
);

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			game <= ROBOTRON;
			mode <= FIRE_4WAY;
			dip  <= 8'h00;
		end
		else if (cfg_wr)
		begin
			if (cfg_index == CFG_GAME)
				game <= game_e'(cfg_data);
			if (cfg_index == CFG_OPTION)
				mode <= ctrl_mode_e'(cfg_data[1:0]);
			// Only DIP bank 0 drives the switch port
			if (cfg_index == CFG_DIP && cfg_addr == 3'd0)
				dip <= cfg_data;
		end
	end

	a_game_known: assert property (@(posedge clk_sys) disable iff (reset)
		(cfg_wr && cfg_index == CFG_GAME)
		|=> game inside {ROBOTRON, JOUST, BUBBLES, ALIENAR, SINISTAR});

endmodule

//--- rtl/pad_merge.sv
/* Stage 1: registers both player pads, forms the merged pad and picks the
   analog stick of the player who last touched a control. */
`timescale 1ns/1ns

module pad_merge
	import ctrl_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    in_valid,
	input  pad_t    pad1,
	input  pad_t    pad2,
	input  axis_t   axis1_x,
	input  axis_t   axis1_y,
	input  axis_t   axis2_x,
	input  axis_t   axis2_y,
	output merged_s out,
	output logic    out_valid
);

	logic last_p2;
	logic sel_p2;

	// Current sample counts already, player 1 wins a tie
	always_comb
	begin
		sel_p2 = last_p2;
		if (in_valid)
		begin
			if (pad1 != '0)
				sel_p2 = 1'b0;
			else if (pad2 != '0)
				sel_p2 = 1'b1;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			last_p2   <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			last_p2   <= sel_p2;
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (in_valid)
		begin
			out.pad1    <= pad1;
			out.pad2    <= pad2;
			out.any_pad <= pad1 | pad2;
			out.x       <= sel_p2 ? axis2_x : axis1_x;
			out.y       <= sel_p2 ? axis2_y : axis1_y;
		end
	end

	a_valid_lag: assert property (@(posedge clk_sys) disable iff (reset)
		1'b1 |=> (out_valid == $past(in_valid)));

endmodule

//--- rtl/stick_quantize.sv
/* Stage 2: turns the selected analog stick into 4-bit position codes, with the
   merged digital directions standing in while the stick is centered. */
`timescale 1ns/1ns

module stick_quantize
	import ctrl_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  merged_s in,
	input  logic    in_valid,
	output quant_s  out,
	output logic    out_valid
);

	stick_pos_t ana_x, ana_y;
	stick_pos_t dig_x, dig_y;

	// The y axis runs the other way, so its codes are mirrored
	function automatic stick_pos_t quant_axis(input axis_t a, input logic flip);
		stick_pos_t lo_far, lo_mid, lo_near;
		stick_pos_t hi_far, hi_mid, hi_near;
		begin
			lo_far  = flip ? POS_MAX : POS_MIN;
			lo_mid  = flip ? POS_POS_MID : POS_NEG_MID;
			lo_near = flip ? POS_POS_NEAR : POS_NEG_NEAR;
			hi_far  = flip ? POS_MIN : POS_MAX;
			hi_mid  = flip ? POS_NEG_MID : POS_POS_MID;
			hi_near = flip ? POS_NEG_NEAR : POS_POS_NEAR;
			if ($signed(a) < -AXIS_FAR)
				quant_axis = lo_far;
			else if ($signed(a) < -AXIS_MID)
				quant_axis = lo_mid;
			else if ($signed(a) < -AXIS_NEAR)
				quant_axis = lo_near;
			else if ($signed(a) > AXIS_FAR)
				quant_axis = hi_far;
			else if ($signed(a) > AXIS_MID)
				quant_axis = hi_mid;
			else if ($signed(a) > AXIS_NEAR)
				quant_axis = hi_near;
			else
				quant_axis = POS_CENTER;
		end
	endfunction

	assign ana_x = quant_axis(in.x, 1'b0);
	assign ana_y = quant_axis(in.y, 1'b1);

	// Left and down take priority over right and up
	assign dig_x = in.any_pad[PAD_LEFT] ? POS_MIN :
		in.any_pad[PAD_RIGHT] ? POS_MAX : POS_CENTER;
	assign dig_y = in.any_pad[PAD_DOWN] ? POS_MIN :
		in.any_pad[PAD_UP] ? POS_MAX : POS_CENTER;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk_sys)
	begin
		if (in_valid)
		begin
			out.merged  <= in;
			out.stick_x <= (ana_x == POS_CENTER) ? dig_x : ana_x;
			out.stick_y <= (ana_y == POS_CENTER) ? dig_y : ana_y;
		end
	end

endmodule

//--- rtl/cabinet_mapper.sv
/* Stage 3: maps pads and stick positions onto the active-low ja, jb and btn
   ports and the sw port, following the selected game and control mode. */
`timescale 1ns/1ns

module cabinet_mapper
	import ctrl_pkg::*;
	import game_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  quant_s     in,
	input  logic       in_valid,
	input  game_e      game,
	input  ctrl_mode_e mode,
	input  logic [7:0] dip,
	output cabinet_s   cab,
	output logic       out_valid
);

	pad_t any_pad, pad1, pad2;
	logic [3:0] robo_hi, robo_lo;
	cabinet_s nxt;

	// Right, left, down, up
	function automatic logic [3:0] dirs(input pad_t p);
		dirs = {p[PAD_RIGHT], p[PAD_LEFT], p[PAD_DOWN], p[PAD_UP]};
	endfunction

	function automatic port_t joust_port(input pad_t p);
		joust_port = ~{5'b00000, p[PAD_FIRE_A], p[PAD_RIGHT], p[PAD_LEFT]};
	endfunction

	function automatic port_t alien_port(input pad_t p);
		alien_port = ~{2'b00, p[PAD_FIRE_B], p[PAD_FIRE_A], dirs(p)};
	endfunction

	assign any_pad = in.merged.any_pad;
	assign pad1    = in.merged.pad1;
	assign pad2    = in.merged.pad2;

	////////////////////////////////////////////////////////////
	// Robotron twin-stick sources

	always_comb
	begin
		case (mode)
			CABINET:
			begin
				robo_hi = dirs(pad2);
				robo_lo = dirs(pad1);
			end
			MOVE_FIRE:
			begin
				robo_hi = dirs(any_pad);
				robo_lo = dirs(any_pad);
			end
			// Four fire buttons act as the fire stick
			default:
			begin
				robo_hi = {any_pad[PAD_FIRE_A], any_pad[PAD_FIRE_D],
					any_pad[PAD_FIRE_B], any_pad[PAD_FIRE_C]};
				robo_lo = dirs(any_pad);
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Per-game port map

	always_comb
	begin
		nxt = CAB_IDLE;
		nxt.sw = dip | {6'b000000, any_pad[PAD_ADVANCE], any_pad[PAD_AUTOUP]};
		case (game)
			ROBOTRON:
			begin
				nxt.btn = ~{any_pad[PAD_START1], any_pad[PAD_START2], any_pad[PAD_COIN]};
				nxt.ja  = ~{robo_hi, robo_lo};
				nxt.jb  = nxt.ja;
			end
			JOUST:
			begin
				nxt.btn = ~{any_pad[PAD_START2], any_pad[PAD_START1], any_pad[PAD_COIN]};
				nxt.ja  = joust_port(pad1);
				nxt.jb  = joust_port(pad2);
			end
			BUBBLES:
			begin
				nxt.btn = ~{any_pad[PAD_START2], any_pad[PAD_START1], any_pad[PAD_COIN]};
				nxt.ja  = ~{4'b0000, dirs(any_pad)};
				nxt.jb  = nxt.ja;
			end
			ALIENAR:
			begin
				nxt.btn = ~{any_pad[PAD_START1], any_pad[PAD_START2], any_pad[PAD_COIN]};
				nxt.ja  = alien_port(pad1);
				nxt.jb  = alien_port(pad2);
			end
			SINISTAR:
			begin
				nxt.btn = ~{any_pad[PAD_START1], any_pad[PAD_START2], any_pad[PAD_COIN]};
				nxt.ja  = ~{in.stick_x, in.stick_y};
				nxt.jb  = nxt.ja;
			end
			default: ;
		endcase
	end

	// Ports fall back to idle between samples
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			cab       <= CAB_IDLE;
			out_valid <= 1'b0;
		end
		else
		begin
			cab       <= in_valid ? nxt : CAB_IDLE;
			out_valid <= in_valid;
		end
	end

	a_btn_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!out_valid |-> (cab.btn == 3'b111));

endmodule

//--- rtl/control_top.sv
/* Control-input front end: pad merge, stick quantize and cabinet port mapping in a
   three-stage pipeline, with the game config loaded through indexed writes. */
`timescale 1ns/1ns

module control_top
	import ctrl_pkg::*;
	import game_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  pad_t       pad1,
	input  pad_t       pad2,
	input  axis_t      axis1_x,
	input  axis_t      axis1_y,
	input  axis_t      axis2_x,
	input  axis_t      axis2_y,
	input  logic       in_valid,
	input  logic       cfg_wr,
	input  logic [7:0] cfg_index,
	input  logic [2:0] cfg_addr,
	input  logic [7:0] cfg_data,
	output cabinet_s   cab,
	output logic       out_valid
);

	merged_s    merged;
	logic       merged_valid;
	quant_s     quant;
	logic       quant_valid;
	game_e      game;
	ctrl_mode_e mode;
	logic [7:0] dip;

	game_config u_config (.clk_sys(clk_sys), .reset(reset), .cfg_wr(cfg_wr),
		.cfg_index(cfg_index), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.game(game), .mode(mode), .dip(dip));

	pad_merge u_merge (.clk_sys(clk_sys), .reset(reset), .in_valid(in_valid),
		.pad1(pad1), .pad2(pad2), .axis1_x(axis1_x), .axis1_y(axis1_y),
		.axis2_x(axis2_x), .axis2_y(axis2_y), .out(merged), .out_valid(merged_valid));

	stick_quantize u_quant (.clk_sys(clk_sys), .reset(reset), .in(merged),
		.in_valid(merged_valid), .out(quant), .out_valid(quant_valid));

	cabinet_mapper u_mapper (.clk_sys(clk_sys), .reset(reset), .in(quant),
		.in_valid(quant_valid), .game(game), .mode(mode), .dip(dip),
		.cab(cab), .out_valid(out_valid));

endmodule

//--- dv/control_tb.sv
/* Testbench for the control front end. Replays the config writes and pad samples of
   the golden file and checks each cabinet port result three cycles after its sample. */
`timescale 1ns/1ns

module control_tb
	import ctrl_pkg::*;
	import game_pkg::*;
();

	localparam string GOLDEN_FILE = "dv/control_golden.txt";
	localparam int PIPE_DEPTH = 3;
	localparam logic [1:0] KIND_CFG    = 2'd0;
	localparam logic [1:0] KIND_SAMPLE = 2'd1;
	localparam logic [1:0] KIND_BURST  = 2'd2;

	typedef struct packed {
		logic [1:0] kind;
		logic [7:0] index;
		logic [2:0] addr;
		logic [7:0] data;
		pad_t p1;
		pad_t p2;
		axis_t a1x;
		axis_t a1y;
		axis_t a2x;
		axis_t a2y;
		cabinet_s exp;
	} entry_s;

	typedef struct {
		int unsigned num;
		int unsigned due;
		cabinet_s exp;
	} pending_s;

	logic clk_sys;
	logic reset;
	pad_t pad1;
	pad_t pad2;
	axis_t axis1_x;
	axis_t axis1_y;
	axis_t axis2_x;
	axis_t axis2_y;
	logic in_valid;
	logic cfg_wr;
	logic [7:0] cfg_index;
	logic [2:0] cfg_addr;
	logic [7:0] cfg_data;
	cabinet_s cab;
	logic out_valid;

	entry_s entries[$];
	pending_s pending[$];
	int unsigned cycle = 0;
	int unsigned sample_count = 0;
	int unsigned watch_limit = 0;
	logic reset_q = 1'b1;
	logic loaded = 1'b0;

	control_top dut (
		.clk_sys(clk_sys), .reset(reset), .pad1(pad1), .pad2(pad2),
		.axis1_x(axis1_x), .axis1_y(axis1_y), .axis2_x(axis2_x), .axis2_y(axis2_y),
		.in_valid(in_valid), .cfg_wr(cfg_wr), .cfg_index(cfg_index),
		.cfg_addr(cfg_addr), .cfg_data(cfg_data), .cab(cab), .out_valid(out_valid)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Stable at the falling edge, where both the driver and the monitor look
	always @(posedge clk_sys)
	begin
		cycle   <= cycle + 1;
		reset_q <= reset;
	end

	////////////////////////////////////////////////////////////
	// Failure and compare tasks

	`include "include/control_checks.svh"

	////////////////////////////////////////////////////////////
	// Golden file reader

	task automatic parse_line(input string line);
		entry_s e;
		byte tag;
		int n;
		logic [7:0] v_index;
		logic [2:0] v_addr;
		logic [7:0] v_data;
		logic [15:0] v_p1;
		logic [15:0] v_p2;
		logic [7:0] v_ax [4];
		logic [7:0] v_ja;
		logic [7:0] v_jb;
		logic [2:0] v_btn;
		logic [7:0] v_sw;
		e = '0;
		n = 0;
		tag = line.getc(0);
		if (tag == "C")
		begin
			n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", v_index, v_addr, v_data);
			e.kind  = KIND_CFG;
			e.index = v_index;
			e.addr  = v_addr;
			e.data  = v_data;
		end
		else if (tag == "S" || tag == "B")
		begin
			n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h %h %h %h",
				v_p1, v_p2, v_ax[0], v_ax[1], v_ax[2], v_ax[3], v_ja, v_jb, v_btn, v_sw);
			e.kind = (tag == "B") ? KIND_BURST : KIND_SAMPLE;
			e.p1   = v_p1;
			e.p2   = v_p2;
			e.a1x  = v_ax[0];
			e.a1y  = v_ax[1];
			e.a2x  = v_ax[2];
			e.a2y  = v_ax[3];
			e.exp  = '{ja: v_ja, jb: v_jb, btn: v_btn, sw: v_sw};
		end
		if ((tag == "C" && n != 3) || (tag != "C" && n != 10))
			abort_run({"malformed line in the golden file: ", line});
		else
			entries.push_back(e);
	endtask

	task automatic load_golden();
		int fd;
		string line;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0)
			abort_run({"cannot open the golden file ", GOLDEN_FILE});
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() > 1 && line.getc(0) != "#")
					parse_line(line);
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Drivers, all on the falling edge

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk_sys);
			in_valid = 1'b0;
		end
	endtask

	// Pipeline must be empty before the config changes
	task automatic write_config(input entry_s e);
		idle_cycles(4);
		@(negedge clk_sys);
		cfg_wr    = 1'b1;
		cfg_index = e.index;
		cfg_addr  = e.addr;
		cfg_data  = e.data;
		@(negedge clk_sys);
		cfg_wr = 1'b0;
	endtask

	task automatic drive_sample(input entry_s e);
		pending_s p;
		@(negedge clk_sys);
		in_valid = 1'b1;
		pad1     = e.p1;
		pad2     = e.p2;
		axis1_x  = e.a1x;
		axis1_y  = e.a1y;
		axis2_x  = e.a2x;
		axis2_y  = e.a2y;
		p.num    = sample_count;
		p.due    = cycle + PIPE_DEPTH;
		p.exp    = e.exp;
		pending.push_back(p);
		sample_count++;
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor

	task automatic check_outputs();
		pending_s p;
		if (out_valid === 1'b1)
		begin
			if (pending.size() == 0)
				abort_run("out_valid went high with no sample in flight");
			else
			begin
				p = pending.pop_front();
				if (p.due != cycle)
					abort_run($sformatf("sample %0d came out on cycle %0d instead of %0d",
						p.num, cycle, p.due));
				else
				begin
					check_port($sformatf("cab.ja sample %0d", p.num), cab.ja, p.exp.ja);
					check_port($sformatf("cab.jb sample %0d", p.num), cab.jb, p.exp.jb);
					check_btn($sformatf("cab.btn sample %0d", p.num), cab.btn, p.exp.btn);
					check_sw($sformatf("cab.sw sample %0d", p.num), cab.sw, p.exp.sw);
				end
			end
		end
		else if (pending.size() != 0 && pending[0].due <= cycle)
			abort_run($sformatf("sample %0d never came out, out_valid stayed low",
				pending[0].num));
		else
		begin
			check_port("cab.ja idle", cab.ja, 8'hff);
			check_port("cab.jb idle", cab.jb, 8'hff);
			check_btn("cab.btn idle", cab.btn, 3'b111);
		end
	endtask

	initial
	begin
		forever
		begin
			@(negedge clk_sys);
			if (!reset_q)
				check_outputs();
		end
	end

	initial
	begin
		wait (loaded === 1'b1);
		repeat (watch_limit) @(posedge clk_sys);
		abort_run($sformatf("watchdog expired after %0d cycles, the run did not finish",
			watch_limit));
	end

	initial
	begin
		reset     = 1'b1;
		in_valid  = 1'b0;
		pad1      = '0;
		pad2      = '0;
		axis1_x   = '0;
		axis1_y   = '0;
		axis2_x   = '0;
		axis2_y   = '0;
		cfg_wr    = 1'b0;
		cfg_index = '0;
		cfg_addr  = '0;
		cfg_data  = '0;
		void'($urandom(28));
		load_golden();
		watch_limit = entries.size() * 8 + 100;
		loaded = 1'b1;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		if (out_valid !== 1'b0)
			abort_run("out_valid is not low after reset");
		else
		begin
			foreach (entries[i])
			begin
				if (entries[i].kind == KIND_CFG)
					write_config(entries[i]);
				else
				begin
					drive_sample(entries[i]);
					// Burst lines go back to back
					if (entries[i].kind == KIND_SAMPLE)
						idle_cycles($urandom % 3);
				end
			end
			idle_cycles(1);
			while (pending.size() != 0)
				@(negedge clk_sys);
			idle_cycles(2);
			$display("** PASS **");
			$finish;
		end
	end

endmodule

//--- dv/control_golden.txt
# C <cfg_index> <cfg_addr> <cfg_data>, all hex
# S|B <pad1> <pad2> <axis1_x> <axis1_y> <axis2_x> <axis2_y> <ja> <jb> <btn> <sw>, B has no idle after
S 0011 0000 00 00 00 00 77 77 7 00
S 0400 1088 00 00 00 00 be be 2 00
S 0066 0800 00 00 00 00 c9 c9 5 00
C 02 0 01
S 0005 0010 00 00 00 00 55 55 7 00
C 02 0 02
S 0002 0009 00 00 00 00 6b 6b 7 00
S 0408 0004 00 00 00 00 de de 3 00
C 01 0 01
S 0011 0802 00 00 00 00 f9 fe 3 00
S 0400 0012 00 00 00 00 ff fa 5 00
C 01 0 05
S 0021 0818 00 00 00 00 d7 ee 5 00
S 0406 0020 00 00 00 00 f9 df 3 00
C 01 0 06
S 0400 0000 b0 64 00 00 bf bf 3 00
S 0001 0000 9c 9c 00 00 f7 f7 7 00
S 0000 0800 9c 9c 64 50 7b 7b 5 00
S 0000 0000 80 80 48 b0 66 66 7 00
S 0004 0009 28 30 9c 9c 49 49 7 00
S 0002 0000 c8 d0 00 00 94 94 7 00
S 0004 0000 20 e0 00 00 8f 8f 7 00
S 000b 0000 00 00 00 00 f7 f7 7 00
C fe 0 84
C fe 1 ff
C 01 0 03
B 2001 0000 00 00 00 00 f7 f7 7 86
B 0000 4002 00 00 00 00 fb fb 7 85
B 1004 6008 00 00 00 00 fc fc 6 87
B 0c00 0000 00 00 00 00 ff ff 1 84
S 0801 0000 00 00 00 00 f7 f7 3 84

//--- verilog.f
rtl/ctrl_pkg.sv
rtl/game_pkg.sv
rtl/game_config.sv
rtl/pad_merge.sv
rtl/stick_quantize.sv
rtl/cabinet_mapper.sv
rtl/control_top.sv
dv/control_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= control_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LINT_FLAGS ?= --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
